/* project.f */
+incdir+common
common/ps2_pkg.sv
common/xt_pkg.sv
ps2_rx/ps2_rx.sv
verilog/scan_translate.sv
verilog/xt_host_port.sv
verilog/pc_keyboard.sv
bench/tb_pc_keyboard.sv

/* Bender.yml */
package:
  name: pc_keyboard

export_include_dirs:
  - common

sources:
  - common/ps2_pkg.sv
  - common/xt_pkg.sv
  - ps2_rx/ps2_rx.sv
  - verilog/scan_translate.sv
  - verilog/xt_host_port.sv
  - verilog/pc_keyboard.sv
  - target: test
    files:
      - bench/tb_pc_keyboard.sv

/* bench/tb_pc_keyboard.sv */
// testbench for pc_keyboard with a PS/2 frame driver, stimulus table, acknowledge and self-test checks
`timescale 1ns/1ps
`include "kbd_params.svh"

module tb_pc_keyboard
	import ps2_pkg::*;
	import xt_pkg::*;
();

	typedef struct packed {
		logic       prefix;  // break prefix sent first
		logic [7:0] code;    // set-2 code
		logic       bad_par; // corrupt the parity bit
		logic [7:0] exp_pa;  // set-1 word the PC should read
	} stim_t;

	localparam int n_tests = 8;
	localparam int half_period = 10; // clk cycles per keyboard clock phase
	localparam int irq_wait = 50;
	localparam int cycle_limit = (n_tests + 2) * (2 * `KBD_FRAME_BITS * 2 * half_period + 100);

	// expected words follow the standard set-2 to set-1 mapping
	localparam stim_t table_q [n_tests] = '{
		'{1'b0, 8'h1C, 1'b0, 8'h1E}, // A
		'{1'b0, 8'h76, 1'b0, 8'h01}, // Esc
		'{1'b0, 8'h5A, 1'b0, 8'h1C}, // Enter
		'{1'b0, 8'h83, 1'b0, 8'h41}, // F7
		'{1'b1, 8'h1C, 1'b0, 8'h9E}, // A released
		'{1'b0, 8'h29, 1'b1, 8'h00}, // space, bad parity, nothing expected
		'{1'b0, 8'h16, 1'b0, 8'h02}, // 1
		'{1'b1, 8'h05, 1'b0, 8'hBB}  // F1 released
	};

	logic clk;
	logic rst_n;
	ps2_line_t ps2;
	xt_ctrl_t host_ctrl;
	xt_scan_u pa;
	logic irq1;

	int cycle_cnt = 0;
	int cur_test = 0;
	int test_err = 0;
	int pass_cnt = 0;
	int fail_cnt = 0;
	int rise_base = 0;
	int irq_rises;
	logic irq_prev;
	integer seed = 72;

	pc_keyboard uut (
		.clk       (clk),
		.rst_n     (rst_n),
		.ps2       (ps2),
		.host_ctrl (host_ctrl),
		.pa        (pa),
		.irq1      (irq1)
	);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	// counts rising edges of irq1
	always @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			irq_prev <= 1'b0;
			irq_rises <= 0;
		end else begin
			irq_prev <= irq1;
			if (irq1 && !irq_prev)
				irq_rises <= irq_rises + 1;
		end
	end

	always @(posedge clk) begin
		cycle_cnt = cycle_cnt + 1;
		if (cycle_cnt >= cycle_limit) begin
			$display("run stopped after %0d cycles without finishing the tests", cycle_cnt);
			$display("CHECKS FAILED");
			$finish;
		end
	end

	task automatic step();
		@(posedge clk);
		#1;
	endtask

	task automatic wait_cycles(input int n);
		repeat (n) step();
	endtask

	// start, 8 data bits LSB first, odd parity, stop
	task automatic send_frame(input logic [7:0] data, input logic bad_par);
		logic [`KBD_FRAME_BITS-1:0] bits;
		bits = {1'b1, ~(^data) ^ bad_par, data, 1'b0};
		for (int i = 0; i < `KBD_FRAME_BITS; i++) begin
			ps2.kb_data = bits[i];
			wait_cycles(half_period);
			ps2.kb_clk = 1'b0;
			wait_cycles(half_period);
			ps2.kb_clk = 1'b1;
		end
		ps2.kb_data = 1'b1;
	endtask

	task automatic wait_irq(output logic seen);
		int n;
		n = 0;
		seen = 1'b0;
		while (!seen && n < irq_wait) begin
			step();
			seen = irq1;
			n++;
		end
	endtask

	task automatic compare_byte(input string sig, input logic [7:0] exp, input logic [7:0] act);
		if (act !== exp) begin
			$display("FAIL test %0d %s expected %h got %h", cur_test, sig, exp, act);
			test_err++;
		end
	endtask

	// pb7 pulse as the PC does it after reading pa
	task automatic ack_irq();
		host_ctrl.pb7 = 1'b1;
		step();
		compare_byte("irq1", 8'h00, {7'b0, irq1});
		host_ctrl.pb7 = 1'b0;
		step();
		compare_byte("pa", 8'h00, pa.raw);
	endtask

	task automatic begin_test();
		cur_test++;
		test_err = 0;
		rise_base = irq_rises;
	endtask

	task automatic finish_test(input string what, input int exp_rises);
		compare_byte("irq1 rises", 8'(exp_rises), 8'(irq_rises - rise_base));
		if (test_err == 0) begin
			pass_cnt++;
			$display("test %0d %s ok", cur_test, what);
		end else begin
			fail_cnt++;
			$display("test %0d %s failed with %0d errors", cur_test, what, test_err);
		end
	endtask

	initial begin
		logic seen;
		int gap;
		stim_t st;
		rst_n = 1'b0;
		ps2 = '1;
		host_ctrl.pb6 = 1'b1;
		host_ctrl.pb7 = 1'b0;
		repeat (10) @(posedge clk);
		#1 rst_n = 1'b1;
		step();

		begin_test();
		compare_byte("pa", 8'h00, pa.raw);
		compare_byte("irq1", 8'h00, {7'b0, irq1});
		finish_test("reset values", 0);

		for (int t = 0; t < n_tests; t++) begin
			st = table_q[t];
			gap = $unsigned($random(seed)) % 16;
			wait_cycles(gap);
			begin_test();
			if (st.prefix)
				send_frame(`KBD_BREAK_PREFIX, 1'b0);
			send_frame(st.code, st.bad_par);
			wait_irq(seen);
			if (st.bad_par) begin
				if (seen) begin
					$display("test %0d: interrupt raised for a frame with bad parity", cur_test);
					test_err++;
				end
				compare_byte("pa", st.exp_pa, pa.raw);
			end else if (!seen) begin
				$display("test %0d: no interrupt after the frame for code %h", cur_test, st.code);
				test_err++;
			end else begin
				compare_byte("pa", st.exp_pa, pa.raw);
				ack_irq();
			end
			finish_test($sformatf("code %h", st.code), st.bad_par ? 0 : 1);
		end

		// second key waits in the translator while the first is unacknowledged
		begin_test();
		send_frame(8'h16, 1'b0);
		send_frame(8'h29, 1'b0);
		step();
		if (!irq1) begin
			$display("test %0d: no interrupt for the first of two keys", cur_test);
			test_err++;
		end
		compare_byte("pa", 8'h02, pa.raw);
		ack_irq();
		wait_irq(seen);
		if (!seen) begin
			$display("test %0d: second key was not delivered after the acknowledge", cur_test);
			test_err++;
		end else begin
			compare_byte("pa", 8'h39, pa.raw);
			ack_irq();
		end
		finish_test("back-pressure", 2);

		// a pending key is cut off by the clock hold before the reply is asked for
		begin_test();
		send_frame(8'h1C, 1'b0);
		wait_irq(seen);
		if (!seen) begin
			$display("test %0d: no interrupt for the key before the self-test", cur_test);
			test_err++;
		end
		host_ctrl.pb6 = 1'b0;
		step();
		compare_byte("irq1", 8'h00, {7'b0, irq1});
		host_ctrl.pb7 = 1'b1;
		wait_cycles(4);
		host_ctrl.pb6 = 1'b1;
		wait_cycles(4);
		compare_byte("irq1", 8'h00, {7'b0, irq1});
		host_ctrl.pb7 = 1'b0;
		wait_irq(seen);
		if (!seen) begin
			$display("test %0d: no interrupt for the self-test reply", cur_test);
			test_err++;
		end else begin
			compare_byte("pa", `KBD_SELFTEST_OK, pa.raw);
			ack_irq();
		end
		finish_test("self-test", 2);

		$display("tests passed %0d failed %0d", pass_cnt, fail_cnt);
		if (fail_cnt == 0)
			$display("ALL CHECKS PASSED");
		else
			$display("CHECKS FAILED");
		$finish;
	end

endmodule

/* verilog/pc_keyboard.sv */
// top level joining the PS/2 receiver, the scan code translator and the PC port
`timescale 1ns/1ps

module pc_keyboard
	import ps2_pkg::*;
	import xt_pkg::*;
(
	input  logic      clk,
	input  logic      rst_n,
	input  ps2_line_t ps2,
	input  xt_ctrl_t  host_ctrl,
	output xt_scan_u  pa,
	output logic      irq1
);

	ps2_byte_t rx_byte; // set-2 byte from the line
	logic rx_valid;
	logic rx_ready;
	xt_scan_u scan; // set-1 word waiting for the PC
	logic scan_valid;
	logic scan_ready;

	ps2_rx u_rx (
		.clk      (clk),
		.rst_n    (rst_n),
		.ps2      (ps2),
		.rx_byte  (rx_byte),
		.rx_valid (rx_valid),
		.rx_ready (rx_ready)
	);

	scan_translate u_xlat (
		.clk        (clk),
		.rst_n      (rst_n),
		.rx_byte    (rx_byte),
		.rx_valid   (rx_valid),
		.rx_ready   (rx_ready),
		.scan       (scan),
		.scan_valid (scan_valid),
		.scan_ready (scan_ready)
	);

	xt_host_port u_host (
		.clk        (clk),
		.rst_n      (rst_n),
		.scan       (scan),
		.scan_valid (scan_valid),
		.scan_ready (scan_ready),
		.host_ctrl  (host_ctrl),
		.pa         (pa),
		.irq1       (irq1)
	);

endmodule

/* verilog/xt_host_port.sv */
// PC-side port FSM for the scan code register, IRQ1, acknowledge and self-test handling
`timescale 1ns/1ps
`include "kbd_params.svh"

module xt_host_port
	import xt_pkg::*;
(
	input  logic     clk,
	input  logic     rst_n,
	input  xt_scan_u scan,
	input  logic     scan_valid,
	output logic     scan_ready,
	input  xt_ctrl_t host_ctrl,
	output xt_scan_u pa,
	output logic     irq1
);

	xt_host_state_e state;

	// no new code while the PC holds the keyboard clock
	assign scan_ready = (state == host_idle) && host_ctrl.pb6;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state <= host_idle;
			pa.raw <= '0;
		end else if (!host_ctrl.pb6) begin
			state <= host_hold; // from any state, pa kept
		end else begin
			case (state)
				host_idle: begin
					if (scan_valid) begin
						pa <= scan;
						state <= host_present;
					end
				end
				host_present: begin
					if (host_ctrl.pb7)
						state <= host_wait_clr; // PC has read pa
				end
				host_wait_clr: begin
					if (!host_ctrl.pb7) begin
						pa.raw <= '0;
						state <= host_idle;
					end
				end
				host_hold: begin
					state <= host_st_release; // clock released
				end
				host_st_release: begin
					// PC drops pb7 to ask for the reply
					if (!host_ctrl.pb7) begin
						pa.raw <= `KBD_SELFTEST_OK;
						state <= host_present;
					end
				end
				default: begin
					state <= host_idle;
				end
			endcase
		end
	end

	// irq1 follows pa by one cycle and drops as soon as pb7 or a low pb6 is seen
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			irq1 <= 1'b0;
		else
			irq1 <= (state == host_present) && host_ctrl.pb6 && !host_ctrl.pb7;
	end

	// stays down in the cycle after a low pb6 and in the hold state after it
	irq_off_in_hold: assert property (@(posedge clk) disable iff (!rst_n)
		!host_ctrl.pb6 |=> !irq1 ##1 !irq1);

	// every way back to idle leaves the port cleared
	pa_clear_in_idle: assert property (@(posedge clk) disable iff (!rst_n)
		state == host_idle |-> pa.raw == 8'h00);

endmodule

/* verilog/scan_translate.sv */
// set-2 to set-1 scan code translator with break prefix merging and an output register
`timescale 1ns/1ps
`include "kbd_params.svh"

module scan_translate
	import ps2_pkg::*;
	import xt_pkg::*;
(
	input  logic      clk,
	input  logic      rst_n,
	input  ps2_byte_t rx_byte,
	input  logic      rx_valid,
	output logic      rx_ready,
	output xt_scan_u  scan,
	output logic      scan_valid,
	input  logic      scan_ready
);

	// set-1 code for every set-2 code below 0x80
	localparam logic [7:0] xlat_lo [128] = '{
		8'hff, 8'h43, 8'h41, 8'h3f, 8'h3d, 8'h3b, 8'h3c, 8'h58,
		8'h64, 8'h44, 8'h42, 8'h40, 8'h3e, 8'h0f, 8'h29, 8'h59,
		8'h65, 8'h38, 8'h2a, 8'h70, 8'h1d, 8'h10, 8'h02, 8'h5a,
		8'h66, 8'h71, 8'h2c, 8'h1f, 8'h1e, 8'h11, 8'h03, 8'h5b,
		8'h67, 8'h2e, 8'h2d, 8'h20, 8'h12, 8'h05, 8'h04, 8'h5c,
		8'h68, 8'h39, 8'h2f, 8'h21, 8'h14, 8'h13, 8'h06, 8'h5d,
		8'h69, 8'h31, 8'h30, 8'h23, 8'h22, 8'h15, 8'h07, 8'h5e,
		8'h6a, 8'h72, 8'h32, 8'h24, 8'h16, 8'h08, 8'h09, 8'h5f,
		8'h6b, 8'h33, 8'h25, 8'h17, 8'h18, 8'h0b, 8'h0a, 8'h60,
		8'h6c, 8'h34, 8'h35, 8'h26, 8'h27, 8'h19, 8'h0c, 8'h61,
		8'h6d, 8'h73, 8'h28, 8'h74, 8'h1a, 8'h0d, 8'h62, 8'h6e,
		8'h3a, 8'h36, 8'h1c, 8'h1b, 8'h75, 8'h2b, 8'h63, 8'h76,
		8'h55, 8'h56, 8'h77, 8'h78, 8'h79, 8'h7a, 8'h0e, 8'h7b,
		8'h7c, 8'h4f, 8'h7d, 8'h4b, 8'h47, 8'h7e, 8'h7f, 8'h6f,
		8'h52, 8'h53, 8'h50, 8'h4c, 8'h4d, 8'h48, 8'h01, 8'h45,
		8'h57, 8'h4e, 8'h51, 8'h4a, 8'h37, 8'h49, 8'h46, 8'h54
	};

	logic [7:0] code_xlat;
	logic accept;
	logic is_prefix;
	logic brk_pend; // prefix seen, next code is a release

	function automatic logic [7:0] to_set1(input ps2_byte_t code);
		logic [7:0] res;
		if (!code[7])
			res = xlat_lo[code[6:0]];
		else if (code == 8'h83)
			res = 8'h41; // F7 sits outside the main block
		else if (code == 8'h84)
			res = 8'h54; // alt+sysrq
		else
			res = code; // no set-1 counterpart
		return res;
	endfunction

	assign rx_ready = !scan_valid || scan_ready;
	assign accept = rx_valid && rx_ready;
	assign is_prefix = (rx_byte == `KBD_BREAK_PREFIX);
	assign code_xlat = to_set1(rx_byte);

	// a prefix produces no output of its own
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			brk_pend <= 1'b0;
			scan_valid <= 1'b0;
		end else if (accept) begin
			brk_pend <= is_prefix;
			scan_valid <= !is_prefix;
		end else if (scan_ready) begin
			scan_valid <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (accept && !is_prefix) begin
			if (brk_pend) begin
				scan.fields.brk <= 1'b1;
				scan.fields.code <= code_xlat[6:0];
			end else begin
				scan.raw <= code_xlat; // make code as looked up
			end
		end
	end

	scan_held: assert property (@(posedge clk) disable iff (!rst_n)
		scan_valid && !scan_ready |=> scan_valid && $stable(scan.raw));

endmodule

/* ps2_rx/ps2_rx.sv */
// PS/2 receiver with line synchronizer, frame deserializer, frame checks and byte output
`timescale 1ns/1ps
`include "kbd_params.svh"

module ps2_rx
	import ps2_pkg::*;
(
	input  logic      clk,
	input  logic      rst_n,
	input  ps2_line_t ps2,
	output ps2_byte_t rx_byte,
	output logic      rx_valid,
	input  logic      rx_ready
);

	localparam int sync_last = `KBD_SYNC_STAGES - 1;
	localparam int cnt_w = $clog2(`KBD_FRAME_BITS);
	localparam int idle_cycles = 4000; // well beyond one bit time
	localparam int idle_w = $clog2(idle_cycles + 1);

	ps2_line_t sync_q [`KBD_SYNC_STAGES];
	logic kclk_prev;
	logic kclk_fall;
	logic [cnt_w-1:0] bit_cnt;
	logic [idle_w-1:0] idle_cnt;
	ps2_frame_t frame_q;
	ps2_frame_t frame_next;
	logic frame_done;
	logic frame_ok;
	logic load;

	// both lines go through the same chain so data stays aligned to the clock
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			for (int i = 0; i < `KBD_SYNC_STAGES; i++)
				sync_q[i] <= '1;
			kclk_prev <= 1'b1;
		end else begin
			sync_q[0] <= ps2;
			for (int i = 1; i < `KBD_SYNC_STAGES; i++)
				sync_q[i] <= sync_q[i-1];
			kclk_prev <= sync_q[sync_last].kb_clk;
		end
	end

	assign kclk_fall = kclk_prev & ~sync_q[sync_last].kb_clk;
	assign frame_next = {sync_q[sync_last].kb_data, frame_q[$bits(ps2_frame_t)-1:1]};
	assign frame_done = kclk_fall && (bit_cnt == cnt_w'(`KBD_FRAME_BITS - 1));

	// start low, stop high, odd parity
	assign frame_ok = !frame_next.start && frame_next.stop &&
		(^{frame_next.data, frame_next.parity});

	// a finished frame is dropped while the last byte still waits
	assign load = frame_done && frame_ok && (!rx_valid || rx_ready);

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			bit_cnt <= '0;
			idle_cnt <= '0;
		end else if (kclk_fall) begin
			idle_cnt <= '0;
			bit_cnt <= frame_done ? '0 : bit_cnt + 1'b1;
		end else if (idle_cnt == idle_w'(idle_cycles)) begin
			bit_cnt <= '0; // line quiet, next edge is a start bit
		end else begin
			idle_cnt <= idle_cnt + 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (kclk_fall)
			frame_q <= frame_next;
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			rx_valid <= 1'b0;
		else if (load)
			rx_valid <= 1'b1;
		else if (rx_ready)
			rx_valid <= 1'b0;
	end

	always_ff @(posedge clk) begin
		if (load)
			rx_byte <= frame_next.data;
	end

	rx_byte_stable: assert property (@(posedge clk) disable iff (!rst_n)
		rx_valid && !rx_ready |=> rx_valid && $stable(rx_byte));

endmodule

/* common/xt_pkg.sv */
// PC-side types for set-1 scan word views, host control lines and port FSM states
package xt_pkg;

	// set-1 code split into release flag and key number
	typedef struct packed {
		logic       brk; // set on key release
		logic [6:0] code;
	} xt_scan_s;

	typedef union packed {
		logic [7:0] raw;
		xt_scan_s   fields;
	} xt_scan_u;

	// port B bits driven by the PC
	typedef struct packed {
		logic pb6; // keyboard clock enable, low holds
		logic pb7; // clear keyboard interrupt
	} xt_ctrl_t;

	typedef enum logic [2:0] {
		host_idle,
		host_present,   // code on pa, irq1 raised
		host_wait_clr,  // waiting for pb7 to fall
		host_hold,      // clock held low by the PC
		host_st_release // self-test reply pending
	} xt_host_state_e;

endpackage

/* common/ps2_pkg.sv */
// keyboard-side types for the line pair, the received byte and the serial frame layout
package ps2_pkg;

	// raw keyboard lines, both idle high
	typedef struct packed {
		logic kb_clk;
		logic kb_data;
	} ps2_line_t;

	typedef logic [7:0] ps2_byte_t; // one set-2 code

	// frame as shifted in LSB first
	// start bit lands in bit 0 after a full frame
	typedef struct packed {
		logic      stop;
		logic      parity; // odd over the data bits
		ps2_byte_t data;
		logic      start;
	} ps2_frame_t;

endpackage

/* common/kbd_params.svh */
// keyboard interface constants for frame size, synchronizer depth and special scan codes
`ifndef KBD_PARAMS_SVH
`define KBD_PARAMS_SVH

// start + 8 data + parity + stop
`define KBD_FRAME_BITS 11

// flops on each keyboard line before use
`define KBD_SYNC_STAGES 2

// set-2 prefix announcing a key release
`define KBD_BREAK_PREFIX 8'hF0

// answer to a PC self-test request
`define KBD_SELFTEST_OK 8'hAA

`endif
